//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of one register value in bits
`define VALUE_WIDTH 32

// Register lanes, picked by the low address bits of a register number
`define NUM_LANES 4

// Rows in one register set, each row holds one value per lane
`define ROWS_PER_SET 8

// Number of register sets, chosen by the regset level
`define REG_SETS 2

`endif

//--- source/alu_execute.sv
`timescale 1ns/10ps

module alu_execute (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dec_valid,
	input  isa_pkg::opcode_t      dec_op,
	input  isa_pkg::full_addr_t   dec_rd,
	input  isa_pkg::full_addr_t   dec_rs0,
	input  isa_pkg::full_addr_t   dec_rs1,
	input  data_pkg::value_t      dec_imm,
	input  data_pkg::value_t      rd0,
	input  data_pkg::value_t      rd1,
	output isa_pkg::full_addr_t   ra0,
	output isa_pkg::full_addr_t   ra1,
	output logic                  ex_valid,
	output isa_pkg::opcode_t      ex_op,
	output isa_pkg::full_addr_t   ex_rd,
	output data_pkg::value_t      ex_value
);

	data_pkg::value_t op0;
	data_pkg::value_t op1;
	data_pkg::value_t alu_out;

	// Source fields go straight to the combinational regfile reads
	assign ra0 = dec_rs0;
	assign ra1 = dec_rs1;

	// The instruction one ahead is still in the execute register and not yet
	// visible in the regfile, so its result is taken from here
	// Register 0 never forwards since it always reads as zero
	always_comb begin
		op0 = rd0;
		op1 = rd1;
		if (ex_valid && dec_rs0 == ex_rd && dec_rs0[4:0] != isa_pkg::REG_ZERO) begin
			op0 = ex_value;
		end
		if (ex_valid && dec_rs1 == ex_rd && dec_rs1[4:0] != isa_pkg::REG_ZERO) begin
			op1 = ex_value;
		end
	end

	// ====================
	// ALU
	// ====================
	always_comb begin
		case (dec_op)
			isa_pkg::OP_ADD: alu_out = op0 + op1;
			isa_pkg::OP_SUB: alu_out = op0 - op1;
			isa_pkg::OP_AND: alu_out = op0 & op1;
			isa_pkg::OP_OR: alu_out = op0 | op1;
			isa_pkg::OP_XOR: alu_out = op0 ^ op1;
			isa_pkg::OP_SLL: alu_out = op0 << op1[4:0];
			isa_pkg::OP_SRL: alu_out = op0 >> op1[4:0];
			isa_pkg::OP_ADDI: alu_out = op0 + dec_imm;
			// LCLOAD, LCDEC and SETMODE finish in the result stage
			default: alu_out = op0;
		endcase
	end

	// NOPs drop out here and never reach the result stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid && dec_op != isa_pkg::OP_NOP;
		end
	end

	always_ff @(posedge clk) begin
		ex_op <= dec_op;
		ex_rd <= dec_rd;
		ex_value <= alu_out;
	end

endmodule

//--- source/data_pkg.sv
`include "core_settings.svh"

package data_pkg;

	// One register value
	typedef logic [`VALUE_WIDTH-1:0] value_t;

	// A full row across all lanes, lane 0 sits in the low bits
	typedef value_t [`NUM_LANES-1:0] row_t;

	// Set bit followed by the row number within the set
	typedef logic [$clog2(`REG_SETS*`ROWS_PER_SET)-1:0] row_addr_t;

	// Operating mode, picks one of the four stack pointers
	typedef logic [1:0] mode_t;

	// Address bits that select the lane
	localparam int LANE_BITS = $clog2(`NUM_LANES);

	// Entries in each lane memory, covering both sets
	localparam int MEM_DEPTH = `REG_SETS * `ROWS_PER_SET;

endpackage

//--- source/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instr_valid,
	input  logic [31:0]           instr,
	input  logic                  regset,
	output logic                  dec_valid,
	output isa_pkg::opcode_t      dec_op,
	output isa_pkg::full_addr_t   dec_rd,
	output isa_pkg::full_addr_t   dec_rs0,
	output isa_pkg::full_addr_t   dec_rs1,
	output data_pkg::value_t      dec_imm
);

	logic [3:0] raw_op;
	isa_pkg::opcode_t op_next;

	// Opcode field straight from the instruction word
	assign raw_op = instr[isa_pkg::OP_HI:isa_pkg::OP_LO];

	// Anything past the last legal code turns into a NOP
	// so the later stages only ever see legal operations
	always_comb begin
		if (raw_op <= isa_pkg::OP_NOP) begin
			op_next = isa_pkg::opcode_t'(raw_op);
		end else begin
			op_next = isa_pkg::OP_NOP;
		end
	end

	// ====================
	// Valid flag
	// ====================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	// Fields load only for an accepted instruction
	// The regset level is sampled with the word and sits on top of every address
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_op <= op_next;
			dec_rd <= {regset, instr[isa_pkg::RD_HI:isa_pkg::RD_LO]};
			dec_rs0 <= {regset, instr[isa_pkg::RS0_HI:isa_pkg::RS0_LO]};
			dec_rs1 <= {regset, instr[isa_pkg::RS1_HI:isa_pkg::RS1_LO]};
			// Size cast of the signed field gives the sign extension
			dec_imm <= data_pkg::value_t'($signed(instr[isa_pkg::IMM_HI:isa_pkg::IMM_LO]));
		end
	end

endmodule

//--- source/int_core_top.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module int_core_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  regset,
	input  logic                  instr_valid,
	input  logic [31:0]           instr,
	input  data_pkg::value_t      sp0,
	input  data_pkg::value_t      sp1,
	input  data_pkg::value_t      sp2,
	input  data_pkg::value_t      sp3,
	input  logic [`NUM_LANES-1:0] grp_we,
	input  data_pkg::row_addr_t   grp_row,
	input  data_pkg::row_t        grp_data,
	input  data_pkg::row_addr_t   grp_ra,
	output data_pkg::row_t        grp_rd,
	output logic                  result_valid,
	output isa_pkg::full_addr_t   result_reg,
	output data_pkg::value_t      result_data,
	output data_pkg::value_t      sc,
	output data_pkg::value_t      lc,
	output data_pkg::mode_t       mode
);

	// Decode to execute
	logic dec_valid;
	isa_pkg::opcode_t dec_op;
	isa_pkg::full_addr_t dec_rd;
	isa_pkg::full_addr_t dec_rs0;
	isa_pkg::full_addr_t dec_rs1;
	data_pkg::value_t dec_imm;

	// Execute and regfile read ports
	isa_pkg::full_addr_t ra0;
	isa_pkg::full_addr_t ra1;
	data_pkg::value_t rd0;
	data_pkg::value_t rd1;

	// Execute to result stage
	logic ex_valid;
	isa_pkg::opcode_t ex_op;
	isa_pkg::full_addr_t ex_rd;
	data_pkg::value_t ex_value;

	// Result stage to regfile write port
	logic wr;
	isa_pkg::full_addr_t wa;
	data_pkg::value_t wdata;

	instr_decode decode_i (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .regset(regset),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_rs0(dec_rs0), .dec_rs1(dec_rs1), .dec_imm(dec_imm)
	);

	regfile regfile_i (
		.clk(clk), .rst(rst), .ra0(ra0), .ra1(ra1), .wr(wr), .wa(wa), .wdata(wdata),
		.lc(lc), .mode(mode), .sp0(sp0), .sp1(sp1), .sp2(sp2), .sp3(sp3),
		.grp_we(grp_we), .grp_row(grp_row), .grp_data(grp_data), .grp_ra(grp_ra),
		.rd0(rd0), .rd1(rd1), .grp_rd(grp_rd), .sc(sc)
	);

	alu_execute execute_i (
		.clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_rs0(dec_rs0), .dec_rs1(dec_rs1), .dec_imm(dec_imm), .rd0(rd0), .rd1(rd1),
		.ra0(ra0), .ra1(ra1), .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
		.ex_value(ex_value)
	);

	writeback_result result_i (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
		.ex_value(ex_value), .wr(wr), .wa(wa), .wdata(wdata), .lc(lc), .mode(mode),
		.result_valid(result_valid), .result_reg(result_reg), .result_data(result_data)
	);

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

	// Operation codes carried in the top nibble of an instruction
	// Codes above OP_NOP are not legal and decode to OP_NOP
	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_ADDI,
		OP_LCLOAD, OP_LCDEC, OP_SETMODE, OP_NOP
	} opcode_t;

	// Register number inside one set
	typedef logic [4:0] reg_addr_t;

	// Set bit on top of the register number
	typedef logic [5:0] full_addr_t;

	// Registers with a special meaning on read or write
	localparam reg_addr_t REG_ZERO = 5'd0;
	localparam reg_addr_t REG_SC = 5'd29;
	localparam reg_addr_t REG_LC = 5'd30;
	localparam reg_addr_t REG_SP = 5'd31;

	// ====================
	// Instruction field positions
	// ====================
	localparam int OP_HI = 31;
	localparam int OP_LO = 28;
	localparam int RD_HI = 27;
	localparam int RD_LO = 23;
	localparam int RS0_HI = 22;
	localparam int RS0_LO = 18;
	localparam int RS1_HI = 17;
	localparam int RS1_LO = 13;
	localparam int IMM_HI = 12;
	localparam int IMM_LO = 0;

endpackage

//--- source/regfile.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module regfile (
	input  logic                  clk,
	input  logic                  rst,
	input  isa_pkg::full_addr_t   ra0,
	input  isa_pkg::full_addr_t   ra1,
	input  logic                  wr,
	input  isa_pkg::full_addr_t   wa,
	input  data_pkg::value_t      wdata,
	input  data_pkg::value_t      lc,
	input  data_pkg::mode_t       mode,
	input  data_pkg::value_t      sp0,
	input  data_pkg::value_t      sp1,
	input  data_pkg::value_t      sp2,
	input  data_pkg::value_t      sp3,
	input  logic [`NUM_LANES-1:0] grp_we,
	input  data_pkg::row_addr_t   grp_row,
	input  data_pkg::row_t        grp_data,
	input  data_pkg::row_addr_t   grp_ra,
	output data_pkg::value_t      rd0,
	output data_pkg::value_t      rd1,
	output data_pkg::row_t        grp_rd,
	output data_pkg::value_t      sc
);

	// Lane bits sit at the bottom of an address, the row bits above them
	localparam int LANE_MSB = data_pkg::LANE_BITS - 1;
	localparam int ROW_MSB = $bits(isa_pkg::full_addr_t) - 1;

	data_pkg::row_addr_t wa_row;
	data_pkg::row_addr_t ra0_row;
	data_pkg::row_addr_t ra1_row;
	data_pkg::row_t lane_rd0;
	data_pkg::row_t lane_rd1;
	data_pkg::value_t sp_sel;

	assign wa_row = wa[ROW_MSB:LANE_MSB+1];
	assign ra0_row = ra0[ROW_MSB:LANE_MSB+1];
	assign ra1_row = ra1[ROW_MSB:LANE_MSB+1];

	// ====================
	// Lane storage
	// ====================
	for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
		localparam logic [LANE_MSB:0] LANE_ID = l;

		data_pkg::value_t mem [data_pkg::MEM_DEPTH];

		// The pipeline write comes last, so it wins when both ports hit one cell
		always_ff @(posedge clk) begin
			if (grp_we[l]) begin
				mem[grp_row] <= grp_data[l];
			end
			if (wr && wa[LANE_MSB:0] == LANE_ID) begin
				mem[wa_row] <= wdata;
			end
		end

		// Every lane reads at the row of each port, the lane bits pick one later
		assign lane_rd0[l] = mem[ra0_row];
		assign lane_rd1[l] = mem[ra1_row];

		// Group read is the raw row with no special registers applied
		assign grp_rd[l] = mem[grp_ra];
	end

	// Stack pointer for the current operating mode
	always_comb begin
		case (mode)
			2'd0: sp_sel = sp0;
			2'd1: sp_sel = sp1;
			2'd2: sp_sel = sp2;
			default: sp_sel = sp3;
		endcase
	end

	// ====================
	// Read ports
	// ====================
	// Priority is zero, then bypass of the write in flight, then lc,
	// then the stack pointer, then the stored value
	function automatic data_pkg::value_t read_port(isa_pkg::full_addr_t ra,
			data_pkg::value_t stored, logic wr_en, isa_pkg::full_addr_t wr_addr,
			data_pkg::value_t wr_data, data_pkg::value_t lc_val,
			data_pkg::value_t sp_val);
		data_pkg::value_t val;
		if (ra[4:0] == isa_pkg::REG_ZERO) begin
			val = '0;
		end else if (wr_en && ra == wr_addr) begin
			val = wr_data;
		end else if (ra[4:0] == isa_pkg::REG_LC) begin
			val = lc_val;
		end else if (ra[4:0] == isa_pkg::REG_SP) begin
			val = sp_val;
		end else begin
			val = stored;
		end
		return val;
	endfunction

	assign rd0 = read_port(ra0, lane_rd0[ra0[LANE_MSB:0]], wr, wa, wdata, lc, sp_sel);
	assign rd1 = read_port(ra1, lane_rd1[ra1[LANE_MSB:0]], wr, wa, wdata, lc, sp_sel);

	// A write to register 29 in either set also lands in sc
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sc <= '0;
		end else if (wr && wa[4:0] == isa_pkg::REG_SC) begin
			sc <= wdata;
		end
	end

endmodule

//--- source/writeback_result.sv
`timescale 1ns/10ps

module writeback_result (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ex_valid,
	input  isa_pkg::opcode_t      ex_op,
	input  isa_pkg::full_addr_t   ex_rd,
	input  data_pkg::value_t      ex_value,
	output logic                  wr,
	output isa_pkg::full_addr_t   wa,
	output data_pkg::value_t      wdata,
	output data_pkg::value_t      lc,
	output data_pkg::mode_t       mode,
	output logic                  result_valid,
	output isa_pkg::full_addr_t   result_reg,
	output data_pkg::value_t      result_data
);

	data_pkg::value_t wb_value;

	// Value that goes to rd, the loop and mode ops report their own number
	always_comb begin
		case (ex_op)
			isa_pkg::OP_LCDEC: wb_value = lc - 1'b1;
			isa_pkg::OP_SETMODE: wb_value = data_pkg::value_t'(mode);
			default: wb_value = ex_value;
		endcase
		// Register 0 reports zero whatever was computed
		if (ex_rd[4:0] == isa_pkg::REG_ZERO) begin
			wb_value = '0;
		end
	end

	// ====================
	// Control and state
	// ====================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result_valid <= 1'b0;
			lc <= '0;
			mode <= '0;
		end else begin
			result_valid <= ex_valid;
			if (ex_valid && ex_op == isa_pkg::OP_LCLOAD) begin
				lc <= ex_value;
			end
			if (ex_valid && ex_op == isa_pkg::OP_LCDEC) begin
				lc <= lc - 1'b1;
			end
			if (ex_valid && ex_op == isa_pkg::OP_SETMODE) begin
				mode <= ex_value[1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			result_reg <= ex_rd;
			result_data <= wb_value;
		end
	end

	// Write port runs off the result register, the array updates one edge later
	assign wr = result_valid && result_reg[4:0] != isa_pkg::REG_ZERO;
	assign wa = result_reg;
	assign wdata = result_data;

endmodule

//--- src.f
+incdir+include
source/isa_pkg.sv
source/data_pkg.sv
source/instr_decode.sv
source/regfile.sv
source/alu_execute.sv
source/writeback_result.sv
source/int_core_top.sv
testbench/tb_int_core.sv

//--- testbench/tb_int_core.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module tb_int_core;

	// 16 row loads, about 430 issue slots with bubbles, 16 row reads and some margin
	localparam int MAX_CYCLES = 600;

	logic clk;
	logic rst;
	logic regset;
	logic instr_valid;
	logic [31:0] instr;
	data_pkg::value_t sp0;
	data_pkg::value_t sp1;
	data_pkg::value_t sp2;
	data_pkg::value_t sp3;
	logic [`NUM_LANES-1:0] grp_we;
	data_pkg::row_addr_t grp_row;
	data_pkg::row_t grp_data;
	data_pkg::row_addr_t grp_ra;
	data_pkg::row_t grp_rd;
	logic result_valid;
	isa_pkg::full_addr_t result_reg;
	data_pkg::value_t result_data;
	data_pkg::value_t sc;
	data_pkg::value_t lc;
	data_pkg::mode_t mode;

	// Model of both register sets and of the special state
	logic [31:0] model_reg [64];
	logic [31:0] model_lc;
	logic [1:0] model_mode;
	logic [31:0] model_sc;

	// Expected results in issue order
	logic [31:0] exp_data [$];
	logic [5:0] exp_reg [$];
	logic [31:0] exp_lc [$];
	logic [1:0] exp_mode [$];
	logic [31:0] exp_sc [$];
	int exp_due [$];
	logic [31:0] e_data;
	logic [5:0] e_reg;
	logic [31:0] e_lc;
	logic [1:0] e_mode;
	logic [31:0] e_sc;
	int e_due;

	// The slot issued just before is kept to spot hazards the pipeline does not cover
	bit prev_valid;
	logic [3:0] prev_op;
	logic [5:0] prev_rd;

	logic [31:0] seed;
	int errors;
	int cycles;

	int_core_top dut_i (
		.clk(clk), .rst(rst), .regset(regset), .instr_valid(instr_valid), .instr(instr),
		.sp0(sp0), .sp1(sp1), .sp2(sp2), .sp3(sp3), .grp_we(grp_we), .grp_row(grp_row),
		.grp_data(grp_data), .grp_ra(grp_ra), .grp_rd(grp_rd), .result_valid(result_valid),
		.result_reg(result_reg), .result_data(result_data), .sc(sc), .lc(lc), .mode(mode)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// Start value of a register cell that depends on the whole full address
	function automatic logic [31:0] fill_value(input logic [5:0] a);
		return ({26'd0, a} * 32'h0101_0101) ^ 32'h5a00_3c00;
	endfunction

	function automatic logic [31:0] encode(input logic [3:0] op, input logic [4:0] rd,
			input logic [4:0] rs0, input logic [4:0] rs1, input logic [12:0] imm);
		return {op, rd, rs0, rs1, imm};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
		end
	endtask

	// A register read as the instruction set defines it
	function automatic logic [31:0] read_model(input logic [5:0] a);
		if (a[4:0] == isa_pkg::REG_ZERO) return 32'd0;
		if (a[4:0] == isa_pkg::REG_LC) return model_lc;
		if (a[4:0] == isa_pkg::REG_SP) begin
			case (model_mode)
				2'd0: return sp0;
				2'd1: return sp1;
				2'd2: return sp2;
				default: return sp3;
			endcase
		end
		return model_reg[a];
	endfunction

	// ====================
	// Reference model
	// ====================
	// Runs one instruction in program order, returns 0 when no result is reported
	function automatic bit ref_exec(input logic [31:0] word, input logic set,
			output logic [31:0] res, output logic [5:0] dst);
		logic [3:0] op;
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] imm;
		logic [31:0] val;
		op = word[31:28];
		dst = {set, word[27:23]};
		v0 = read_model({set, word[22:18]});
		v1 = read_model({set, word[17:13]});
		imm = {{19{word[12]}}, word[12:0]};
		res = 32'd0;
		case (op)
			isa_pkg::OP_ADD: val = v0 + v1;
			isa_pkg::OP_SUB: val = v0 - v1;
			isa_pkg::OP_AND: val = v0 & v1;
			isa_pkg::OP_OR: val = v0 | v1;
			isa_pkg::OP_XOR: val = v0 ^ v1;
			isa_pkg::OP_SLL: val = v0 << v1[4:0];
			isa_pkg::OP_SRL: val = v0 >> v1[4:0];
			isa_pkg::OP_ADDI: val = v0 + imm;
			isa_pkg::OP_LCLOAD: begin
				model_lc = v0;
				val = v0;
			end
			isa_pkg::OP_LCDEC: begin
				model_lc = model_lc - 1;
				val = model_lc;
			end
			isa_pkg::OP_SETMODE: begin
				val = {30'd0, model_mode};
				model_mode = v0[1:0];
			end
			// NOP and the unused codes leave no trace
			default: return 1'b0;
		endcase
		if (dst[4:0] == isa_pkg::REG_ZERO) begin
			val = 32'd0;
		end else begin
			model_reg[dst] = val;
			if (dst[4:0] == isa_pkg::REG_SC) model_sc = val;
		end
		res = val;
		return 1'b1;
	endfunction

	// Issues one instruction on the falling edge and queues what it should report
	// Reads of lc or the stack pointer right after an lc or mode change, and reads of
	// the target of LCDEC or SETMODE one slot later, get a bubble slot first
	task automatic issue(input logic [31:0] word, input logic set);
		bit hazard;
		bit has_res;
		logic [31:0] res;
		logic [5:0] dst;
		logic [31:0] sc_before;
		hazard = 1'b0;
		if (prev_valid && (prev_op == isa_pkg::OP_LCLOAD || prev_op == isa_pkg::OP_LCDEC
				|| prev_op == isa_pkg::OP_SETMODE)) begin
			if (word[22:18] >= 5'd30 || word[17:13] >= 5'd30) hazard = 1'b1;
			if (prev_op != isa_pkg::OP_LCLOAD && ({set, word[22:18]} == prev_rd
					|| {set, word[17:13]} == prev_rd)) hazard = 1'b1;
		end
		if (hazard) begin
			instr_valid = 1'b0;
			@(negedge clk);
		end
		// sc lags one edge behind the result, so the check sees the value from before
		sc_before = model_sc;
		has_res = ref_exec(word, set, res, dst);
		if (has_res) begin
			exp_data.push_back(res);
			exp_reg.push_back(dst);
			exp_lc.push_back(model_lc);
			exp_mode.push_back(model_mode);
			exp_sc.push_back(sc_before);
			exp_due.push_back(cycles + 3);
		end
		regset = set;
		instr = word;
		instr_valid = 1'b1;
		@(negedge clk);
		prev_valid = 1'b1;
		prev_op = word[31:28];
		prev_rd = {set, word[27:23]};
	endtask

	task automatic idle(input int n);
		instr_valid = 1'b0;
		repeat (n) @(negedge clk);
		prev_valid = 1'b0;
	endtask

	// Fills every row of both sets through the group port and reads each one back
	task automatic load_rows();
		logic [5:0] a;
		for (int r = 0; r < data_pkg::MEM_DEPTH; r++) begin
			grp_we = '1;
			grp_row = r;
			grp_ra = r;
			for (int l = 0; l < `NUM_LANES; l++) begin
				a = r * `NUM_LANES + l;
				grp_data[l] = fill_value(a);
				model_reg[a] = fill_value(a);
			end
			@(negedge clk);
			for (int l = 0; l < `NUM_LANES; l++) begin
				check_value("grp_rd", grp_rd[l], model_reg[r * `NUM_LANES + l]);
			end
		end
		grp_we = '0;
	endtask

	task automatic compare_rows();
		for (int r = 0; r < data_pkg::MEM_DEPTH; r++) begin
			grp_ra = r;
			@(negedge clk);
			for (int l = 0; l < `NUM_LANES; l++) begin
				check_value("grp_rd", grp_rd[l], model_reg[r * `NUM_LANES + l]);
			end
		end
	endtask

	// ====================
	// Result checking
	// ====================
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			assert (exp_data.size() > 0) else begin
				errors++;
				$display("A result for register %h arrived with nothing expected", result_reg);
			end
			if (exp_data.size() > 0) begin
				e_data = exp_data.pop_front();
				e_reg = exp_reg.pop_front();
				e_lc = exp_lc.pop_front();
				e_mode = exp_mode.pop_front();
				e_sc = exp_sc.pop_front();
				e_due = exp_due.pop_front();
				check_value("result_data", result_data, e_data);
				check_value("result_reg", result_reg, e_reg);
				check_value("lc", lc, e_lc);
				check_value("mode", mode, e_mode);
				check_value("sc", sc, e_sc);
				assert (cycles == e_due) else begin
					errors++;
					$display("Result for register %h came at cycle %0d instead of cycle %0d",
						result_reg, cycles, e_due);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with %0d errors", cycles, errors);
			$display("Finished with errors");
			$finish;
		end
	end

	// ====================
	// Stimulus
	// ====================
	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		rst = 1'b1;
		regset = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		sp0 = 32'h0000_f000;
		sp1 = 32'h1111_e000;
		sp2 = 32'h2222_d000;
		sp3 = 32'h3333_c000;
		grp_we = '0;
		grp_row = '0;
		grp_data = '0;
		grp_ra = '0;
		seed = 32'd81011;
		errors = 0;
		cycles = 0;
		prev_valid = 1'b0;
		prev_op = '0;
		prev_rd = '0;
		model_lc = '0;
		model_mode = '0;
		model_sc = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("result_valid", result_valid, 0);
		check_value("sc", sc, 0);
		check_value("lc", lc, 0);
		check_value("mode", mode, 0);
		load_rows();

		// A dependent chain takes one ahead from execute and two ahead from the bypass
		issue(encode(isa_pkg::OP_ADDI, 1, 2, 0, 13'h0123), 1'b0);
		issue(encode(isa_pkg::OP_ADD, 3, 1, 1, 0), 1'b0);
		issue(encode(isa_pkg::OP_SUB, 4, 3, 1, 0), 1'b0);
		issue(encode(isa_pkg::OP_XOR, 5, 4, 3, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADDI, 6, 5, 0, 13'h1f00), 1'b0);
		issue(encode(isa_pkg::OP_SLL, 7, 6, 4, 0), 1'b0);
		issue(encode(isa_pkg::OP_SRL, 8, 7, 3, 0), 1'b0);
		issue(encode(isa_pkg::OP_AND, 9, 8, 6, 0), 1'b0);
		issue(encode(isa_pkg::OP_OR, 10, 9, 2, 0), 1'b0);
		idle(1);

		// Register 0 drops writes, then the stack pointer follows SETMODE
		issue(encode(isa_pkg::OP_ADDI, 0, 1, 0, 13'h0055), 1'b0);
		issue(encode(isa_pkg::OP_OR, 9, 0, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADDI, 10, 0, 0, 2), 1'b0);
		issue(encode(isa_pkg::OP_SETMODE, 11, 10, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADD, 12, 31, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADDI, 10, 0, 0, 3), 1'b0);
		issue(encode(isa_pkg::OP_SETMODE, 11, 10, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADD, 12, 31, 0, 0), 1'b0);

		// Loop counter, then a write to register 29 that lands in sc
		issue(encode(isa_pkg::OP_ADDI, 13, 0, 0, 5), 1'b0);
		issue(encode(isa_pkg::OP_LCLOAD, 14, 13, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_LCDEC, 15, 0, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_LCDEC, 16, 0, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADD, 17, 30, 0, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADDI, 29, 17, 0, 13'h0100), 1'b0);
		idle(4);
		check_value("sc", sc, model_sc);

		// Same register numbers in both sets must stay apart
		issue(encode(isa_pkg::OP_ADDI, 1, 0, 0, 13'h0abc), 1'b1);
		issue(encode(isa_pkg::OP_ADD, 2, 1, 1, 0), 1'b0);
		issue(encode(isa_pkg::OP_ADD, 3, 1, 1, 0), 1'b1);

		// Random programs keep rd below 30 and the top codes decode as NOP
		for (int i = 0; i < 400; i++) begin
			r = next_rand();
			r2 = next_rand();
			issue(encode(r[30:27], r2[30:16] % 30, r[26:22], r[21:17], r[16:4]), r2[24]);
		end
		idle(6);

		assert (exp_data.size() == 0) else begin
			errors++;
			$display("%0d expected results never arrived", exp_data.size());
		end
		check_value("sc", sc, model_sc);
		check_value("lc", lc, model_lc);
		check_value("mode", mode, model_mode);
		compare_rows();

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
